// File: sim.f
common/eg_pkg.sv
rtl/eg_rate_gen.sv
eg_core/eg_state_loop.sv
eg_core/eg_level_loop.sv
rtl/eg_post.sv
rtl/eg_top.sv
verif/eg_props.sv
verif/tb_eg.sv

// File: run.sh
#!/bin/sh
# compile and run the envelope generator testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_eg -o tb_eg
./obj_dir/tb_eg

// File: verif/tb_eg.sv
`timescale 1ns/10ps
`default_nettype none

module tb_eg;
    import eg_pkg::*;

    localparam int N_OPS  = 32;
    localparam int SETTLE = 8;     // post stages plus margin

    logic       i_EMUCLK;
    logic       mrst_n;
    logic       i_kon;
    rate_t      i_ar;
    rate_t      i_d1r;
    rate_t      i_d2r;
    rr_t        i_rr;
    d1l_t       i_d1l;
    tl_t        i_tl;
    ams_t       i_ams;
    lfa_t       i_lfa;
    logic       i_test_loud;
    logic       o_slot_first;
    logic       o_pg_phase_rst;
    atten_t     o_atten;

    int         seed = 81;
    int         pulse_cnt = 0;  // phase-reset pulses seen so far
    int         pulse_base;
    int         slot_phase = 0; // slot expected on the output, counted from reset
    logic       chk_en;
    atten_t     exp_atten;
    atten_t     attack_out;     // output of the locked attack level
    atten_t     hist [N_OPS];   // last output per slot

    eg_top #(.N_OPS(N_OPS)) i_dut (
        .i_EMUCLK       (i_EMUCLK),
        .mrst_n         (mrst_n),
        .i_kon          (i_kon),
        .i_ar           (i_ar),
        .i_d1r          (i_d1r),
        .i_d2r          (i_d2r),
        .i_rr           (i_rr),
        .i_d1l          (i_d1l),
        .i_tl           (i_tl),
        .i_ams          (i_ams),
        .i_lfa          (i_lfa),
        .i_test_loud    (i_test_loud),
        .o_slot_first   (o_slot_first),
        .o_pg_phase_rst (o_pg_phase_rst),
        .o_atten        (o_atten)
    );

    always #50 i_EMUCLK = ~i_EMUCLK; // 100 ns period

    ////////////////////////////////////////////////////////////
    // reference model of the output stages

    function automatic atten_t eg_expected_post(input atten_t level, input ams_t ams,
                                                input lfa_t lfa, input tl_t tl,
                                                input logic loud);
        int am;
        int sum;
        case (ams)
            2'd0:    am = 0;               // am off
            2'd1:    am = int'(lfa);
            2'd2:    am = int'(lfa) * 2;
            default: am = int'(lfa) * 4;
        endcase
        sum = int'(level) + am;
        if (sum > 1023) sum = 1023;
        sum = sum + int'(tl) * 8;        // tl in steps of 8
        if (sum > 1023) sum = 1023;
        if (loud) sum = 0;
        return atten_t'(sum);
    endfunction

    // expected output for a level with the registers as driven now
    function automatic atten_t exp_now(input atten_t level);
        return eg_expected_post(level, i_ams, i_lfa, i_tl, i_test_loud);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic chk_atten(input atten_t got, input atten_t want, input string what);
        if (got !== want) begin
            stop_run($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, want));
        end
    endtask

    task automatic chk_pulse_count(input int got, input int want, input string what);
        if (got != want) begin
            stop_run($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, want));
        end
    endtask

    task automatic chk_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_run($sformatf("ERR @%0t: %s is %0b, expected %0b", $time, what, got, want));
        end
    endtask

    task automatic chk_not_below(input atten_t got, input atten_t floor, input string what);
        if (got < floor) begin
            stop_run($sformatf("ERR @%0t: %s fell from %0d to %0d", $time, what, floor, got));
        end
    endtask

    // compare process, runs on the falling edge
    always @(negedge i_EMUCLK) begin
        if (chk_en) chk_atten(o_atten, exp_atten, "o_atten");
        if (o_pg_phase_rst) pulse_cnt++;
        if (mrst_n) begin
            chk_flag(o_slot_first, slot_phase == 0, "o_slot_first"); // slot 0 once a frame
            slot_phase = (slot_phase == N_OPS - 1) ? 0 : slot_phase + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers

    task automatic randomize_post_regs();
        @(posedge i_EMUCLK);
        i_ams <= ams_t'($random(seed));
        i_lfa <= lfa_t'($random(seed));
        i_tl  <= tl_t'($random(seed));
    endtask

    // wait for a value on o_atten, limit counts falling edges
    task automatic wait_atten(input atten_t want, input int limit, input string what);
        int n;
        n = 1;
        @(negedge i_EMUCLK);
        while (o_atten !== want) begin
            if (n >= limit) begin
                stop_run($sformatf("timeout: %s, o_atten did not reach %0d", what, want));
            end
            @(negedge i_EMUCLK);
            n++;
        end
    endtask

    task automatic check_frame(input atten_t want);
        @(posedge i_EMUCLK);
        exp_atten <= want;
        chk_en    <= 1'b1;
        repeat (N_OPS) @(posedge i_EMUCLK);
        chk_en <= 1'b0;
    endtask

    // same slot compared one frame apart
    task automatic follow_release(input int limit);
        int                       n;
        int                       quiet_run;
        logic [$clog2(N_OPS)-1:0] idx;
        n         = 0;
        quiet_run = 0;
        idx       = '0;
        while (quiet_run < N_OPS) begin
            if (n >= limit) begin
                stop_run("timeout: release did not bring every slot to the quiet level");
            end
            @(negedge i_EMUCLK);
            if (n >= N_OPS) chk_not_below(o_atten, hist[idx], "o_atten in release");
            hist[idx] = o_atten;
            quiet_run = (o_atten == ATTEN_QUIET) ? quiet_run + 1 : 0;
            idx       = idx + 1'b1;
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        i_EMUCLK    = 1'b0;
        mrst_n      = 1'b0;
        i_kon       = 1'b0;
        i_ar        = '0;
        i_d1r       = '0;
        i_d2r       = '0;
        i_rr        = '0;
        i_d1l       = '0;
        i_tl        = '0;
        i_ams       = '0;
        i_lfa       = '0;
        i_test_loud = 1'b0;
        chk_en      = 1'b0;
        exp_atten   = ATTEN_QUIET;

        repeat (10) @(posedge i_EMUCLK);
        mrst_n <= 1'b1;

        // idle, key off
        repeat (N_OPS) @(posedge i_EMUCLK);
        randomize_post_regs();
        repeat (SETTLE) @(posedge i_EMUCLK);
        wait_atten(exp_now(ATTEN_QUIET), N_OPS, "idle level");
        check_frame(exp_now(ATTEN_QUIET));

        // instant attack setup, then key on
        @(posedge i_EMUCLK);
        i_ar  <= 5'd31;
        i_d1r <= 5'd0;
        i_d2r <= 5'd0;
        i_d1l <= 4'd0;
        randomize_post_regs();
        repeat (SETTLE) @(posedge i_EMUCLK);
        i_kon <= 1'b1;
        pulse_base = pulse_cnt;
        repeat (2 * N_OPS) @(posedge i_EMUCLK);
        chk_pulse_count(pulse_cnt - pulse_base, N_OPS, "phase-reset pulses after key-on");
        pulse_base = pulse_cnt;
        repeat (N_OPS) @(posedge i_EMUCLK); // three frames after key-on
        attack_out = exp_now(10'd0);
        check_frame(attack_out);
        chk_pulse_count(pulse_cnt - pulse_base, 0, "phase-reset pulses with key held");

        // test bit forces full volume
        @(posedge i_EMUCLK);
        i_test_loud <= 1'b1;
        wait_atten(10'd0, 5, "test bit forcing loud");
        check_frame(10'd0);
        @(posedge i_EMUCLK);
        i_test_loud <= 1'b0;
        wait_atten(attack_out, SETTLE, "output after test bit cleared");
        check_frame(attack_out);

        // release to quiet
        @(posedge i_EMUCLK);
        i_ams <= 2'd0;
        i_tl  <= 7'd0;
        i_rr  <= 4'd15;
        i_kon <= 1'b0;
        repeat (SETTLE) @(posedge i_EMUCLK);
        follow_release(20000);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/eg_props.sv
`timescale 1ns/10ps
`default_nettype none

module eg_props (
    input  wire                     i_EMUCLK,
    input  wire                     mrst_n,
    input  wire                     i_kon_detected,
    input  wire eg_pkg::env_state_e i_state_prev,
    input  wire                     i_third_sample,
    input  wire eg_pkg::atten_t     i_delta,
    input  wire                     i_atten_inc,
    input  wire                     i_atten_dec,
    input  wire eg_pkg::atten_t     i_lvl_c9,
    input  wire eg_pkg::atten_t     i_lvl_sum
);
    import eg_pkg::*;

    logic no_attack; // decay or release, no fresh key-on

    assign no_attack = !i_kon_detected && (i_state_prev != ATTACK);

    ////////////////////////////////////////////////////////////
    // level loop properties

    a_inc_dec_excl: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        !(i_atten_inc && i_atten_dec))
        else $error("increment and decrement active in the same cycle");

    // c9 to sum is three stages
    a_level_no_fall: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        $past(no_attack, 3) |-> i_lvl_sum >= $past(i_lvl_c9, 3))
        else $error("level fell in decay or release");

    // weight to adder step is two stages
    a_weight_idle: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        $past(!i_third_sample, 2) |-> i_delta == '0)
        else $error("level step outside a third-sample frame");

endmodule

bind eg_level_loop eg_props u_props (
    .i_EMUCLK       (i_EMUCLK),
    .mrst_n         (mrst_n),
    .i_kon_detected (i_kon_detected),
    .i_state_prev   (i_state_prev),
    .i_third_sample (i_third_sample),
    .i_delta        (delta),
    .i_atten_inc    (atten_inc),
    .i_atten_dec    (atten_dec),
    .i_lvl_c9       (lvl_c9),
    .i_lvl_sum      (lvl_sum)
);

`default_nettype wire

// File: rtl/eg_top.sv
`timescale 1ns/10ps
`default_nettype none

module eg_top #(
    parameter int N_OPS = 32
) (
    input  wire                     i_EMUCLK,
    input  wire                     mrst_n,
    input  wire                     i_kon,
    input  wire eg_pkg::rate_t      i_ar,
    input  wire eg_pkg::rate_t      i_d1r,
    input  wire eg_pkg::rate_t      i_d2r,
    input  wire eg_pkg::rr_t        i_rr,
    input  wire eg_pkg::d1l_t       i_d1l,
    input  wire eg_pkg::tl_t        i_tl,
    input  wire eg_pkg::ams_t       i_ams,
    input  wire eg_pkg::lfa_t       i_lfa,
    input  wire                     i_test_loud,
    output logic                    o_slot_first,
    output logic                    o_pg_phase_rst,
    output eg_pkg::atten_t          o_atten
);
    import eg_pkg::*;

    logic       third_sample;
    envcntr_t   envcntr;
    attenrate_t attenrate;
    logic       kon_current;
    logic       kon_detected;
    env_state_e state_prev;
    logic [5:0] rate;         // scaled rate
    logic       atten_min;
    logic       atten_max;
    logic       d1_end;
    atten_t     level;

    eg_rate_gen #(.N_OPS(N_OPS)) u_rate_gen (
        .i_EMUCLK       (i_EMUCLK),
        .mrst_n         (mrst_n),
        .o_slot_first   (o_slot_first),
        .o_third_sample (third_sample),
        .o_envcntr      (envcntr),
        .o_attenrate    (attenrate)
    );

    // state loop and level loop run in lockstep on the same slot
    eg_state_loop #(.N_OPS(N_OPS)) u_state_loop (
        .i_EMUCLK       (i_EMUCLK),
        .mrst_n         (mrst_n),
        .i_kon          (i_kon),
        .i_ar           (i_ar),
        .i_d1r          (i_d1r),
        .i_d2r          (i_d2r),
        .i_rr           (i_rr),
        .i_atten_min    (atten_min),
        .i_atten_max    (atten_max),
        .i_d1_end       (d1_end),
        .o_pg_phase_rst (o_pg_phase_rst),
        .o_kon_current  (kon_current),
        .o_kon_detected (kon_detected),
        .o_state_prev   (state_prev),
        .o_rate         (rate)
    );

    eg_level_loop #(.N_OPS(N_OPS)) u_level_loop (
        .i_EMUCLK       (i_EMUCLK),
        .mrst_n         (mrst_n),
        .i_kon_current  (kon_current),
        .i_kon_detected (kon_detected),
        .i_state_prev   (state_prev),
        .i_rate         (rate),
        .i_d1l          (i_d1l),
        .i_third_sample (third_sample),
        .i_envcntr      (envcntr),
        .i_attenrate    (attenrate),
        .o_atten_min    (atten_min),
        .o_atten_max    (atten_max),
        .o_d1_end       (d1_end),
        .o_level        (level)
    );

    eg_post u_post (
        .i_EMUCLK    (i_EMUCLK),
        .mrst_n      (mrst_n),
        .i_level     (level),
        .i_ams       (i_ams),
        .i_lfa       (i_lfa),
        .i_tl        (i_tl),
        .i_test_loud (i_test_loud),
        .o_atten     (o_atten)
    );

endmodule

`default_nettype wire

// File: rtl/eg_post.sv
`timescale 1ns/10ps
`default_nettype none

module eg_post (
    input  wire                     i_EMUCLK,
    input  wire                     mrst_n,
    input  wire eg_pkg::atten_t     i_level,
    input  wire eg_pkg::ams_t       i_ams,
    input  wire eg_pkg::lfa_t       i_lfa,
    input  wire eg_pkg::tl_t        i_tl,
    input  wire                     i_test_loud,
    output eg_pkg::atten_t          o_atten
);
    import eg_pkg::*;

    atten_t      lvl_s1;
    atten_t      lfa_s1;
    atten_t      mod_s2;
    atten_t      tl_s3;
    tl_t         tl_s1;
    tl_t         tl_s2;
    logic        loud_s1;
    logic        loud_s2;
    logic        loud_s3;
    logic [10:0] mod_add;
    logic [10:0] tl_add;

    assign mod_add = {1'b0, lvl_s1} + {1'b0, lfa_s1};
    assign tl_add  = {1'b0, mod_s2} + {1'b0, tl_s2, 3'b000}; // tl in steps of 8

    // am depth, ams 0 turns it off
    always_ff @(posedge i_EMUCLK) begin
        unique case (i_ams)
            2'd0: lfa_s1 <= '0;
            2'd1: lfa_s1 <= {2'b00, i_lfa};
            2'd2: lfa_s1 <= {1'b0, i_lfa, 1'b0};
            2'd3: lfa_s1 <= {i_lfa, 2'b00};
        endcase
        tl_s1 <= i_tl;
        tl_s2 <= tl_s1;
    end

    ////////////////////////////////////////////////////////////
    // four stages, level in to o_atten

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            lvl_s1  <= ATTEN_QUIET;
            mod_s2  <= ATTEN_QUIET;
            tl_s3   <= ATTEN_QUIET;
            o_atten <= ATTEN_QUIET;
            loud_s1 <= 1'b0;
            loud_s2 <= 1'b0;
            loud_s3 <= 1'b0;
        end else begin
            lvl_s1  <= i_level;
            loud_s1 <= i_test_loud;
            mod_s2  <= mod_add[10] ? ATTEN_QUIET : mod_add[9:0]; // clamp quiet
            loud_s2 <= loud_s1;
            tl_s3   <= tl_add[10] ? ATTEN_QUIET : tl_add[9:0];
            loud_s3 <= loud_s2;
            o_atten <= loud_s3 ? '0 : tl_s3; // test bit, full volume
        end
    end

endmodule

`default_nettype wire

// File: eg_core/eg_level_loop.sv
`timescale 1ns/10ps
`default_nettype none

module eg_level_loop #(
    parameter int N_OPS = 32
) (
    input  wire                     i_EMUCLK,
    input  wire                     mrst_n,
    input  wire                     i_kon_current,
    input  wire                     i_kon_detected,
    input  wire eg_pkg::env_state_e i_state_prev,
    input  wire [5:0]               i_rate,
    input  wire eg_pkg::d1l_t       i_d1l,
    input  wire                     i_third_sample,
    input  wire eg_pkg::envcntr_t   i_envcntr,
    input  wire eg_pkg::attenrate_t i_attenrate,
    output logic                    o_atten_min,
    output logic                    o_atten_max,
    output logic                    o_d1_end,
    output eg_pkg::atten_t          o_level
);
    import eg_pkg::*;

    localparam int STORE_LEN = N_OPS - 4;          // c9, c10, gated, sum make up the rest
    localparam logic [15:0] INTENSITY = 16'h7510;  // strong step, by {rate[1:0], envcntr}

    atten_t     lvl_c9;
    atten_t     lvl_c10;
    atten_t     lvl_gated;
    atten_t     lvl_sum;
    atten_t     lvl_store [STORE_LEN];
    atten_t     delta;
    dweight_t   dweight_c;
    dweight_t   dweight;
    logic       rate_zero;
    logic       rate_full;
    logic       intensity;
    logic [5:0] rate_appl;
    logic       atten_inc;   // quieter, decay and release
    logic       atten_dec;   // louder, attack
    logic       fix_max;
    logic       enable_prev;

    ////////////////////////////////////////////////////////////
    // flags from the slot's previous level

    assign o_atten_min = lvl_c9 == '0;
    assign o_atten_max = lvl_c9 >= ATTEN_DECAY_MAX;
    assign o_d1_end    = lvl_c9[9:4] == {(i_d1l == 4'd15), i_d1l, 1'b0}; // d1l 15 maps past 31
    assign o_level     = lvl_store[STORE_LEN-1];

    assign rate_zero = i_rate == 6'd0;
    assign rate_full = i_rate[5:1] == 5'b11111;
    assign intensity = INTENSITY[{i_rate[1:0], i_envcntr}];
    assign rate_appl = i_rate + {i_attenrate, 2'b00}; // carry dropped

    // step weight, only in a third-sample frame
    always_comb begin
        dweight_c = 4'b0000;
        if (i_third_sample) begin
            case (i_rate[5:2])
                4'b1111: dweight_c = 4'b1000;
                4'b1110: dweight_c = intensity ? 4'b1000 : 4'b0100;
                4'b1101: dweight_c = intensity ? 4'b0100 : 4'b0010;
                4'b1100: dweight_c = intensity ? 4'b0010 : 4'b0001;
                default: begin
                    // slow rates step only when the applied rate hits this set
                    if (!rate_zero && (rate_appl inside {6'd48, 6'd49, 6'd50, 6'd51,
                                                         6'd54, 6'd55, 6'd57, 6'd59})) begin
                        dweight_c = 4'b0001;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // step control

    always_ff @(posedge i_EMUCLK) begin
        dweight     <= dweight_c;
        fix_max     <= (i_state_prev != ATTACK) && !i_kon_detected && o_atten_max;
        enable_prev <= !i_kon_detected || !rate_full; // full-rate key-on starts from 0
        if (!mrst_n) begin
            atten_inc <= 1'b0;
            atten_dec <= 1'b0;
        end else begin
            atten_inc <= !i_kon_detected && !o_atten_max &&
                         ((i_state_prev == FIRST_DECAY && !o_d1_end) ||
                          i_state_prev == SECOND_DECAY || i_state_prev == RELEASE);
            atten_dec <= i_state_prev == ATTACK && i_kon_current && !o_atten_min && !rate_full;
        end
    end

    // signed step, attack uses a negative step scaled by the level itself
    always_ff @(posedge i_EMUCLK) begin
        unique case ({atten_dec, atten_inc})
            2'b01: delta <= {6'b000000, dweight};
            2'b10: begin
                case (dweight)
                    4'b0001: delta <= {4'b1111, ~lvl_c10[9:5], ~lvl_c10[3]};
                    4'b0010: delta <= {3'b111, ~lvl_c10[9:5], ~lvl_c10[3], ~lvl_c10[1]};
                    4'b0100: delta <= {2'b11, ~lvl_c10[9:5], ~lvl_c10[3], {2{~lvl_c10[2]}}};
                    4'b1000: delta <= {1'b1, ~lvl_c10[9:5], {4{~lvl_c10[4]}}};
                    default: delta <= '0;
                endcase
            end
            default: delta <= '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // level ring, N_OPS stages in all

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            lvl_c9    <= ATTEN_QUIET;
            lvl_c10   <= ATTEN_QUIET;
            lvl_gated <= ATTEN_QUIET;
            lvl_sum   <= ATTEN_QUIET;
            for (int i = 0; i < STORE_LEN; i++) lvl_store[i] <= ATTEN_QUIET;
        end else begin
            lvl_c9  <= lvl_store[STORE_LEN-1];
            lvl_c10 <= lvl_c9;
            if (fix_max)          lvl_gated <= ATTEN_QUIET; // snap to quiet
            else if (enable_prev) lvl_gated <= lvl_c10;
            else                  lvl_gated <= '0;
            lvl_sum <= lvl_gated + delta; // wraps, the step never crosses 0
            lvl_store[0] <= lvl_sum;
            for (int i = 1; i < STORE_LEN; i++) lvl_store[i] <= lvl_store[i-1];
        end
    end

endmodule

`default_nettype wire

// File: eg_core/eg_state_loop.sv
`timescale 1ns/10ps
`default_nettype none

module eg_state_loop #(
    parameter int N_OPS = 32
) (
    input  wire                     i_EMUCLK,
    input  wire                     mrst_n,
    input  wire                     i_kon,
    input  wire eg_pkg::rate_t      i_ar,
    input  wire eg_pkg::rate_t      i_d1r,
    input  wire eg_pkg::rate_t      i_d2r,
    input  wire eg_pkg::rr_t        i_rr,
    input  wire                     i_atten_min,
    input  wire                     i_atten_max,
    input  wire                     i_d1_end,
    output logic                    o_pg_phase_rst,
    output logic                    o_kon_current,
    output logic                    o_kon_detected,
    output eg_pkg::env_state_e      o_state_prev,
    output logic [5:0]              o_rate
);
    import eg_pkg::*;

    localparam int HIST_LEN  = N_OPS - 4; // previous key, ahead of the 4-stage tail
    localparam int STORE_LEN = N_OPS - 5; // 4 pre stages + fsm register close the ring

    logic [3:0]          kon_cur_dly;   // lines up the key with the level pipeline
    logic [HIST_LEN-1:0] kon_prev_hist;
    logic [3:0]          kon_prev_dly;
    env_state_e          state_pre [4];
    env_state_e          state_cur;
    env_state_e          state_store [STORE_LEN];
    rate_t               rate_sel;
    rate_t               rate_c8;

    ////////////////////////////////////////////////////////////
    // key-on history, edge = now high, N_OPS cycles ago low

    assign o_kon_current  = kon_cur_dly[3];
    assign o_kon_detected = kon_cur_dly[3] & ~kon_prev_dly[3];
    assign o_pg_phase_rst = o_kon_detected;
    assign o_state_prev   = state_pre[3];

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            kon_cur_dly   <= '0;
            kon_prev_hist <= '0;
            kon_prev_dly  <= '0;
        end else begin
            kon_cur_dly   <= {kon_cur_dly[2:0], i_kon};
            kon_prev_hist <= {kon_prev_hist[HIST_LEN-2:0], kon_cur_dly[3]};
            kon_prev_dly  <= {kon_prev_dly[2:0], kon_prev_hist[HIST_LEN-1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // state ring, one entry per slot

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            for (int i = 0; i < 4; i++) state_pre[i] <= RELEASE;
            for (int i = 0; i < STORE_LEN; i++) state_store[i] <= RELEASE;
        end else begin
            // an early edge already picks the attack rate
            state_pre[0] <= (i_kon && !kon_prev_hist[HIST_LEN-1]) ? ATTACK
                                                                   : state_store[STORE_LEN-1];
            for (int i = 1; i < 4; i++) state_pre[i] <= state_pre[i-1];
            state_store[0] <= state_cur;
            for (int i = 1; i < STORE_LEN; i++) state_store[i] <= state_store[i-1];
        end
    end

    // envelope fsm, flags come back from the level loop in the same cycle
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            state_cur <= RELEASE;
        end else if (o_kon_detected) begin
            state_cur <= ATTACK;
        end else if (!o_kon_current) begin
            state_cur <= RELEASE; // key off
        end else begin
            unique case (state_pre[3])
                ATTACK:       state_cur <= i_atten_min ? FIRST_DECAY : ATTACK;
                FIRST_DECAY: begin
                    if (i_atten_max)   state_cur <= RELEASE;
                    else if (i_d1_end) state_cur <= SECOND_DECAY;
                    else               state_cur <= FIRST_DECAY;
                end
                SECOND_DECAY: state_cur <= i_atten_max ? RELEASE : SECOND_DECAY;
                RELEASE:      state_cur <= RELEASE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // rate per state, two cycles ahead of the level stage

    always_comb begin
        unique case (state_pre[1])
            ATTACK:       rate_sel = i_ar;
            FIRST_DECAY:  rate_sel = i_d1r;
            SECOND_DECAY: rate_sel = i_d2r;
            RELEASE:      rate_sel = {i_rr, 1'b0};
        endcase
    end

    always_ff @(posedge i_EMUCLK) begin
        rate_c8 <= rate_sel;
        o_rate  <= {rate_c8, 1'b0}; // no key-scale term, tops out at 62
    end

endmodule

`default_nettype wire

// File: rtl/eg_rate_gen.sv
`timescale 1ns/10ps
`default_nettype none

module eg_rate_gen #(
    parameter int N_OPS = 32
) (
    input  wire                     i_EMUCLK,
    input  wire                     mrst_n,
    output logic                    o_slot_first,
    output logic                    o_third_sample,
    output eg_pkg::envcntr_t        o_envcntr,
    output eg_pkg::attenrate_t      o_attenrate
);
    import eg_pkg::*;

    // 5 bits minimum so slot 16 always fits
    localparam int SLOT_W = ($clog2(N_OPS) < 5) ? 5 : $clog2(N_OPS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(N_OPS - 1);
    localparam logic [SLOT_W-1:0] ADD_END   = SLOT_W'(16); // serial add on slots 0..15
    localparam logic [SLOT_W-1:0] ZERO_END  = SLOT_W'(14); // bits 0..13 scanned on slots 1..14

    logic [SLOT_W-1:0] slot_cnt;
    logic              slot_last;
    logic              add_win;
    logic [1:0]        sample_cnt;
    logic [14:0]       time_sr;   // 16-cell ring together with tsum
    logic              tsum;
    logic              tcarry;
    logic [1:0]        tadd;
    logic              one_seen;
    attenrate_t        zero_cnt;

    ////////////////////////////////////////////////////////////
    // slot and sample counters

    assign slot_last      = slot_cnt == LAST_SLOT;
    assign add_win        = slot_cnt < ADD_END;
    assign o_slot_first   = slot_cnt == '0;
    assign o_third_sample = sample_cnt[1]; // high one frame out of three

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            slot_cnt   <= '0;
            sample_cnt <= 2'd0;
        end else begin
            slot_cnt <= slot_last ? '0 : slot_cnt + 1'b1;
            if (slot_last) begin
                sample_cnt <= sample_cnt[1] ? 2'd0 : sample_cnt + 2'd1; // 0,1,2
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // serial time counter, lsb first

    // carry-in of 1 at slot 0 makes the +1, only in a third-sample frame
    assign tadd = {1'b0, o_third_sample & (o_slot_first | tcarry)} + {1'b0, time_sr[0]};

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            time_sr <= '0;
            tsum    <= 1'b0;
            tcarry  <= 1'b0;
        end else if (add_win) begin
            {tcarry, tsum} <= tadd;
            time_sr        <= {tsum, time_sr[14:1]}; // ring holds still outside the window
        end
    end

    // count zero bits from the lsb until the first one
    // first one at bit k gives k+1, fourteen zeros give 0
    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n || o_slot_first) begin
            one_seen <= 1'b0;
            zero_cnt <= 4'd1;
        end else if (slot_cnt <= ZERO_END && !one_seen) begin
            if (tsum) begin
                one_seen <= 1'b1; // tsum holds the bit of the previous slot
            end else begin
                zero_cnt <= (zero_cnt == 4'd14) ? 4'd0 : zero_cnt + 4'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // frame-end latch

    always_ff @(posedge i_EMUCLK) begin
        if (!mrst_n) begin
            o_envcntr   <= 2'd0;
            o_attenrate <= 4'd0;
        end else if (slot_last && o_third_sample) begin
            // on a 16-slot frame the last shift lands on this same edge
            o_envcntr   <= add_win ? time_sr[3:2] : time_sr[2:1];
            o_attenrate <= zero_cnt;
        end
    end

endmodule

`default_nettype wire

// File: common/eg_pkg.sv
`default_nettype none

package eg_pkg;

    typedef logic [9:0] atten_t;     // 0 loud, 1023 quiet
    typedef logic [4:0] rate_t;      // ar, d1r, d2r, or rr doubled
    typedef logic [3:0] rr_t;
    typedef logic [3:0] d1l_t;
    typedef logic [6:0] tl_t;
    typedef logic [7:0] lfa_t;       // am value from the lfo
    typedef logic [1:0] ams_t;
    typedef logic [3:0] attenrate_t; // 0..14 from the rate generator
    typedef logic [1:0] envcntr_t;   // sample phase, time counter bits 2:1
    typedef logic [3:0] dweight_t;   // one-hot step weight

    typedef enum logic [1:0] {
        ATTACK       = 2'd0,
        FIRST_DECAY  = 2'd1,
        SECOND_DECAY = 2'd2,
        RELEASE      = 2'd3
    } env_state_e;

    localparam atten_t ATTEN_QUIET     = 10'd1023;
    localparam atten_t ATTEN_DECAY_MAX = 10'd1008; // top 6 bits all set

endpackage

`default_nettype wire
